//--- verilog/wbdown_pkg.sv
package wbdown_pkg;

	////////////////////////////////////////////////////////////
	// Bus geometry
	////////////////////////////////////////////////////////////
	localparam int WIDE_DW    = 64;
	localparam int SMALL_DW   = 32;
	localparam int ADDR_WIDTH = 28;

	// Small beats per wide request
	localparam int RATIO = WIDE_DW / SMALL_DW;
	localparam int SUB_W = $clog2(RATIO);

	// Word addresses
	localparam int WIDE_AW  = ADDR_WIDTH - $clog2(WIDE_DW / 8);
	localparam int SMALL_AW = ADDR_WIDTH - $clog2(SMALL_DW / 8);

	// Default ack FIFO depth as log2
	localparam int LGFIFO_DEF = 5;

	typedef logic [WIDE_DW-1:0]       wide_data_t;
	typedef logic [SMALL_DW-1:0]      small_data_t;
	typedef logic [WIDE_DW/8-1:0]     wide_sel_t;
	typedef logic [SMALL_DW/8-1:0]    small_sel_t;
	typedef logic [WIDE_AW-1:0]       wide_addr_t;
	typedef logic [SMALL_AW-1:0]      small_addr_t;
	typedef logic [SUB_W-1:0]         sub_addr_t;

	// Counts 0 up to RATIO inclusive
	typedef logic [$clog2(RATIO+1)-1:0] beat_cnt_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SEND,
		ST_OPEN
	} ctrl_state_t;

endpackage

//--- verilog/wbdown_ctrl.sv
`timescale 1ns/1ns

module wbdown_ctrl (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_wcyc,
	input  logic i_wstb,
	input  logic i_wwe,
	input  logic i_sstall,
	input  logic i_serr,
	input  logic i_werr,
	input  logic i_full,
	input  logic i_last_beat,
	input  logic i_more_beats,
	output logic o_scyc,
	output logic o_sstb,
	output logic o_swe,
	output logic o_wstall,
	output logic o_req_take,
	output logic o_beat_go,
	output logic o_abort
);
	import wbdown_pkg::*;

	ctrl_state_t state;
	logic        r_we;

	////////////////////////////////////////////////////////////
	// Handshake terms
	////////////////////////////////////////////////////////////

	// Dropped cycle, a fresh bus error, or the error being reported
	assign o_abort = !i_wcyc || (o_scyc && i_serr) || i_werr;

	// Beat held back while the ack FIFO has no room
	assign o_sstb    = (state == ST_SEND) && !i_full;
	assign o_beat_go = o_sstb && !i_sstall;

	// Upstream waits for all but the last beat, and for any held beat
	assign o_wstall   = i_more_beats || ((state == ST_SEND) && (i_full || i_sstall));
	assign o_req_take = i_wcyc && i_wstb && !o_wstall;

	assign o_scyc = (state != ST_IDLE);
	assign o_swe  = r_we;

	////////////////////////////////////////////////////////////
	// Cycle state
	////////////////////////////////////////////////////////////
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
			state <= ST_IDLE;
		else if (o_abort)
			state <= ST_IDLE;
		else if (o_req_take)
			state <= ST_SEND;
		else if (o_beat_go && i_last_beat)
			state <= ST_OPEN;
	end

	// Write enable follows the most recent request
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
			r_we <= 1'b0;
		else if (o_abort)
			r_we <= 1'b0;
		else if (o_req_take)
			r_we <= i_wwe;
	end

	// No strobe and no beats left once the cycle is down
	a_idle_quiet: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(state == ST_IDLE) |-> (!o_sstb && !i_more_beats))
		else $error("wbdown_ctrl: beat activity outside a bus cycle");

endmodule

//--- verilog/beat_counter.sv
`timescale 1ns/1ns

module beat_counter (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic                  i_req_take,
	input  logic                  i_beat_go,
	input  logic                  i_abort,
	output logic                  o_last_beat,
	output logic                  o_more_beats,
	output wbdown_pkg::sub_addr_t o_sub_addr
);
	import wbdown_pkg::*;

	beat_cnt_t count;
	sub_addr_t sub;

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			count <= '0;
			sub   <= '0;
		end
		else if (i_abort)
		begin
			count <= '0;
			sub   <= '0;
		end
		else if (i_req_take)
		begin
			// Upper word goes out first
			count <= beat_cnt_t'(RATIO);
			sub   <= '0;
		end
		else if (i_beat_go)
		begin
			count <= count - 1'b1;
			sub   <= sub + 1'b1;
		end
	end

	assign o_last_beat  = (count == beat_cnt_t'(1));
	assign o_more_beats = (count > beat_cnt_t'(1));
	assign o_sub_addr   = sub;

	a_count_sub: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(count != '0) |-> (count + sub == RATIO))
		else $error("beat_counter: count and sub-address out of step");

endmodule

//--- verilog/req_shifter.sv
`timescale 1ns/1ns

module req_shifter (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  logic                    i_req_take,
	input  logic                    i_beat_go,
	input  logic                    i_abort,
	input  wbdown_pkg::wide_addr_t  i_waddr,
	input  wbdown_pkg::wide_data_t  i_wdata,
	input  wbdown_pkg::wide_sel_t   i_wsel,
	output wbdown_pkg::wide_addr_t  o_word_addr,
	output wbdown_pkg::small_data_t o_sdata,
	output wbdown_pkg::small_sel_t  o_ssel
);
	import wbdown_pkg::*;

	localparam int SSEL_W = $bits(small_sel_t);

	wide_addr_t r_addr;
	wide_data_t s_data;
	wide_sel_t  s_sel;

	// Select lanes cleared so a dead request drives no bytes
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
			s_sel <= '0;
		else if (i_abort)
			s_sel <= '0;
		else if (i_req_take)
			s_sel <= i_wsel;
		else if (i_beat_go)
			s_sel <= s_sel << SSEL_W;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_req_take)
		begin
			r_addr <= i_waddr;
			s_data <= i_wdata;
		end
		else if (i_beat_go)
			s_data <= s_data << SMALL_DW;
	end

	// Big-endian order keeps the current beat in the top word
	assign o_sdata     = s_data[WIDE_DW-1 -: SMALL_DW];
	assign o_ssel      = s_sel[WIDE_DW/8-1 -: SSEL_W];
	assign o_word_addr = r_addr;

endmodule

//--- verilog/ack_fifo.sv
`timescale 1ns/1ns

module ack_fifo #(
	parameter int LGFIFO = wbdown_pkg::LGFIFO_DEF
) (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_flush,
	input  logic i_push,
	input  logic i_push_last,
	input  logic i_pop,
	output logic o_full,
	output logic o_head_last
);

	localparam int DEPTH = 1 << LGFIFO;

	logic [DEPTH-1:0]  flags;
	logic [LGFIFO:0]   wr_ptr;
	logic [LGFIFO:0]   rd_ptr;
	logic [LGFIFO:0]   fill;
	logic              empty;

	// Fill never exceeds DEPTH, so its top bit alone means full
	assign fill   = wr_ptr - rd_ptr;
	assign empty  = (fill == '0);
	assign o_full = fill[LGFIFO];

	////////////////////////////////////////////////////////////
	// Pointers
	////////////////////////////////////////////////////////////
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else if (i_flush)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (i_push && !o_full)
				wr_ptr <= wr_ptr + 1'b1;
			if (i_pop && !empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Flag storage
	always_ff @(posedge i_clk)
	begin
		if (i_push && !o_full)
			flags[wr_ptr[LGFIFO-1:0]] <= i_push_last;
	end

	assign o_head_last = flags[rd_ptr[LGFIFO-1:0]];

	// Every small ack must match a beat sent earlier
	a_no_underflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_pop && !i_flush) |-> !empty)
		else $error("ack_fifo: acknowledge with no beat outstanding");

endmodule

//--- verilog/resp_assembler.sv
`timescale 1ns/1ns

module resp_assembler (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  logic                    i_abort,
	input  logic                    i_scyc,
	input  logic                    i_sack,
	input  wbdown_pkg::small_data_t i_sdata,
	input  logic                    i_serr,
	input  logic                    i_head_last,
	output logic                    o_wack,
	output wbdown_pkg::wide_data_t  o_wdata,
	output logic                    o_werr
);
	import wbdown_pkg::*;

	logic last_ack;

	// Ack of the final beat of a wide request
	assign last_ack = i_scyc && i_sack && i_head_last;

	////////////////////////////////////////////////////////////
	// Response strobes
	////////////////////////////////////////////////////////////
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_wack <= 1'b0;
			o_werr <= 1'b0;
		end
		else
		begin
			o_wack <= last_ack && !i_abort;
			// Cycle drops on the same edge, so this is a single pulse
			o_werr <= i_scyc && i_serr;
		end
	end

	// First beat ends up in the upper half after the last one shifts in
	always_ff @(posedge i_clk)
	begin
		if (i_scyc && i_sack)
			o_wdata <= {o_wdata[WIDE_DW-SMALL_DW-1:0], i_sdata};
	end

endmodule

//--- verilog/wbdown_top.sv
`timescale 1ns/1ns

module wbdown_top #(
	parameter int LGFIFO = wbdown_pkg::LGFIFO_DEF
) (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	// Upstream wide port
	input  logic                     i_wcyc,
	input  logic                     i_wstb,
	input  logic                     i_wwe,
	input  wbdown_pkg::wide_addr_t   i_waddr,
	input  wbdown_pkg::wide_data_t   i_wdata,
	input  wbdown_pkg::wide_sel_t    i_wsel,
	output logic                     o_wstall,
	output logic                     o_wack,
	output wbdown_pkg::wide_data_t   o_wdata,
	output logic                     o_werr,
	// Downstream small port
	output logic                     o_scyc,
	output logic                     o_sstb,
	output logic                     o_swe,
	output wbdown_pkg::small_addr_t  o_saddr,
	output wbdown_pkg::small_data_t  o_sdata,
	output wbdown_pkg::small_sel_t   o_ssel,
	input  logic                     i_sstall,
	input  logic                     i_sack,
	input  wbdown_pkg::small_data_t  i_sdata,
	input  logic                     i_serr
);
	import wbdown_pkg::*;

	logic        req_take;
	logic        beat_go;
	logic        abort;
	logic        last_beat;
	logic        more_beats;
	logic        full;
	logic        head_last;
	sub_addr_t   sub_addr;
	wide_addr_t  word_addr;

	// Small address is the latched wide word plus the beat index
	assign o_saddr = {word_addr, sub_addr};

	wbdown_ctrl u_ctrl (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_wcyc(i_wcyc), .i_wstb(i_wstb), .i_wwe(i_wwe),
		.i_sstall(i_sstall), .i_serr(i_serr), .i_werr(o_werr),
		.i_full(full), .i_last_beat(last_beat), .i_more_beats(more_beats),
		.o_scyc(o_scyc), .o_sstb(o_sstb), .o_swe(o_swe),
		.o_wstall(o_wstall), .o_req_take(req_take),
		.o_beat_go(beat_go), .o_abort(abort)
	);

	beat_counter u_count (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_req_take(req_take), .i_beat_go(beat_go), .i_abort(abort),
		.o_last_beat(last_beat), .o_more_beats(more_beats),
		.o_sub_addr(sub_addr)
	);

	req_shifter u_shift (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_req_take(req_take), .i_beat_go(beat_go), .i_abort(abort),
		.i_waddr(i_waddr), .i_wdata(i_wdata), .i_wsel(i_wsel),
		.o_word_addr(word_addr), .o_sdata(o_sdata), .o_ssel(o_ssel)
	);

	// One flag per beat in flight; acks outside a cycle are ignored
	ack_fifo #(
		.LGFIFO(LGFIFO)
	) u_fifo (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_flush(abort), .i_push(beat_go), .i_push_last(last_beat),
		.i_pop(i_sack && o_scyc),
		.o_full(full), .o_head_last(head_last)
	);

	resp_assembler u_resp (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_abort(abort), .i_scyc(o_scyc), .i_sack(i_sack),
		.i_sdata(i_sdata), .i_serr(i_serr), .i_head_last(head_last),
		.o_wack(o_wack), .o_wdata(o_wdata), .o_werr(o_werr)
	);

endmodule

//--- test/tb_clkgen.sv
`timescale 1ns/1ns

module tb_clkgen (
	output logic o_clk,
	output logic o_rst_n
);
	initial
	begin
		o_clk   = 1'b0;
		o_rst_n = 1'b0;
		// Release just after the 16th rising edge
		#(16 * 20 + 2) o_rst_n = 1'b1;
	end

	always #10 o_clk = ~o_clk;

endmodule

//--- test/tb_checker.sv
`timescale 1ns/1ns

module tb_checker (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  logic                    i_wcyc,
	input  logic                    i_wstb,
	input  logic                    i_wwe,
	input  wbdown_pkg::wide_addr_t  i_waddr,
	input  wbdown_pkg::wide_data_t  i_wdata,
	input  wbdown_pkg::wide_sel_t   i_wsel,
	input  logic                    i_wstall,
	input  logic                    i_wack,
	input  logic                    i_werr,
	input  wbdown_pkg::wide_data_t  i_wrdata,
	input  logic                    i_scyc,
	input  logic                    i_sstb,
	input  logic                    i_swe,
	input  wbdown_pkg::small_addr_t i_saddr,
	input  wbdown_pkg::small_data_t i_sdata,
	input  wbdown_pkg::small_sel_t  i_ssel,
	input  logic                    i_sstall,
	input  logic                    i_sack,
	input  logic                    i_serr,
	output int                      o_errors,
	output int                      o_checks,
	output int                      o_pending
);
	import wbdown_pkg::*;

	logic        req_we[$];
	wide_addr_t  req_addr[$];
	logic        beat_we[$];
	small_addr_t beat_addr[$];
	small_data_t beat_data[$];
	small_sel_t  beat_sel[$];
	int          sacks = 0;
	logic        err_due = 1'b0;
	logic        held = 1'b0;
	logic [63:0] held_bus;

	initial
	begin
		o_errors = 0;
		o_checks = 0;
	end

	task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
		o_checks++;
		if (exp !== act)
		begin
			o_errors++;
			$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic complain(input string what);
		o_errors++;
		$display("%0t: %s", $time, what);
	endtask

	always @(posedge i_clk)
	begin
		if (i_rst_n)
		begin
			////////////////////////////////////////////////////////////
			// Predict the beats of each accepted wide request
			////////////////////////////////////////////////////////////
			if (i_wcyc && i_wstb && !i_wstall)
			begin
				req_we.push_back(i_wwe);
				req_addr.push_back(i_waddr);
				for (int k = 0; k < RATIO; k++)
				begin
					beat_we.push_back(i_wwe);
					beat_addr.push_back(small_addr_t'(i_waddr) * RATIO + k);
					beat_data.push_back(i_wdata[WIDE_DW-1-k*SMALL_DW -: SMALL_DW]);
					beat_sel.push_back(i_wsel[WIDE_DW/8-1-k*(SMALL_DW/8) -: SMALL_DW/8]);
				end
				if (i_sstb && i_sstall)
					complain("upstream request taken while the small bus stalls");
			end
			// Stalled beat must hold
			if (held)
				compare("stalled sstb/saddr/sdata/ssel", held_bus,
					{i_sstb, i_saddr, i_sdata, i_ssel});
			held = i_sstb && i_sstall;
			held_bus = {i_sstb, i_saddr, i_sdata, i_ssel};
			if (i_scyc && i_sstb && !i_sstall)
			begin
				if (beat_addr.size() == 0)
					complain("small beat with no wide request behind it");
				else
				begin
					compare("o_saddr", beat_addr.pop_front(), i_saddr);
					compare("o_swe", beat_we[0], i_swe);
					if (beat_we.pop_front())
					begin
						compare("o_sdata", beat_data[0], i_sdata);
						compare("o_ssel", beat_sel[0], i_ssel);
					end
					void'(beat_data.pop_front());
					void'(beat_sel.pop_front());
				end
			end
			////////////////////////////////////////////////////////////
			// Wide responses
			////////////////////////////////////////////////////////////
			if (i_scyc && i_sack)
				sacks++;
			if (err_due)
			begin
				compare("o_werr", 1'b1, i_werr);
				compare("o_scyc", 1'b0, i_scyc);
				if (req_addr.size() != 0)
				begin
					void'(req_addr.pop_front());
					void'(req_we.pop_front());
				end
				beat_we.delete();
				beat_addr.delete();
				beat_data.delete();
				beat_sel.delete();
				sacks = 0;
			end
			else if (i_werr)
				complain("wide error with no small error before it");
			err_due = i_scyc && i_serr;
			if (i_wack)
			begin
				if (req_addr.size() == 0)
					complain("wide acknowledge with no request outstanding");
				else
				begin
					if (sacks < RATIO)
						complain("wide acknowledge before its last small acknowledge");
					sacks -= RATIO;
					if (!req_we.pop_front())
						compare("o_wdata",
							{~SMALL_DW'(req_addr[0] * RATIO),
							~SMALL_DW'(req_addr[0] * RATIO + 1)},
							i_wrdata);
					void'(req_addr.pop_front());
				end
			end
		end
		o_pending = req_addr.size();
	end

endmodule

//--- test/tb_wbdown.sv
`timescale 1ns/1ns

module tb_wbdown;
	import wbdown_pkg::*;

	typedef struct packed {
		logic       we;
		logic       err;
		logic [7:0] mask;
		wide_addr_t addr;
		wide_data_t data;
		wide_sel_t  sel;
	} entry_t;

	logic clk, rst_n;
	logic i_wcyc, i_wstb, i_wwe, o_wstall, o_wack, o_werr;
	wide_addr_t i_waddr;
	wide_data_t i_wdata, o_wdata;
	wide_sel_t  i_wsel;
	logic o_scyc, o_sstb, o_swe, i_sstall, i_sack, i_serr;
	small_addr_t o_saddr;
	small_data_t o_sdata, i_sdata;
	small_sel_t  o_ssel;
	int errors, checks, pending;

	entry_t      tbl[$];
	small_addr_t pend_addr[$];
	int          pend_ready[$];
	int seed = 29085;
	int cyc = 0;
	int last_ready = 0;
	int ack_delay;
	int acc_cnt = 0;
	int resp_cnt = 0;
	logic [7:0] stall_bits = '0;
	logic err_armed = 1'b0;
	logic acc;

	tb_clkgen u_clk (.o_clk(clk), .o_rst_n(rst_n));

	wbdown_top UUT (
		.i_clk(clk), .i_rst_n(rst_n),
		.i_wcyc(i_wcyc), .i_wstb(i_wstb), .i_wwe(i_wwe), .i_waddr(i_waddr),
		.i_wdata(i_wdata), .i_wsel(i_wsel), .o_wstall(o_wstall), .o_wack(o_wack),
		.o_wdata(o_wdata), .o_werr(o_werr), .o_scyc(o_scyc), .o_sstb(o_sstb),
		.o_swe(o_swe), .o_saddr(o_saddr), .o_sdata(o_sdata), .o_ssel(o_ssel),
		.i_sstall(i_sstall), .i_sack(i_sack), .i_sdata(i_sdata), .i_serr(i_serr)
	);

	tb_checker u_check (
		.i_clk(clk), .i_rst_n(rst_n), .i_wcyc(i_wcyc), .i_wstb(i_wstb), .i_wwe(i_wwe),
		.i_waddr(i_waddr), .i_wdata(i_wdata), .i_wsel(i_wsel), .i_wstall(o_wstall),
		.i_wack(o_wack), .i_werr(o_werr), .i_wrdata(o_wdata), .i_scyc(o_scyc),
		.i_sstb(o_sstb), .i_swe(o_swe), .i_saddr(o_saddr), .i_sdata(o_sdata),
		.i_ssel(o_ssel), .i_sstall(i_sstall), .i_sack(i_sack), .i_serr(i_serr),
		.o_errors(errors), .o_checks(checks), .o_pending(pending)
	);

	////////////////////////////////////////////////////////////
	// Small bus slave that acks in order after 1 to 3 cycles
	////////////////////////////////////////////////////////////
	always @(posedge clk)
	begin
		cyc++;
		if (o_wack || o_werr)
			resp_cnt <= resp_cnt + 1;
		if (o_scyc && o_sstb && !i_sstall)
		begin
			ack_delay = $unsigned($random(seed)) % 3;
			if (cyc + ack_delay > last_ready)
				last_ready = cyc + ack_delay;
			else
				last_ready = last_ready + 1;
			pend_addr.push_back(o_saddr);
			pend_ready.push_back(last_ready);
		end
		#2;
		i_sack = 1'b0;
		i_serr = 1'b0;
		i_sstall = stall_bits[0];
		stall_bits = stall_bits >> 1;
		if (!o_scyc)
		begin
			pend_addr.delete();
			pend_ready.delete();
		end
		else if (pend_ready.size() != 0 && pend_ready[0] <= cyc)
		begin
			void'(pend_ready.pop_front());
			i_sdata = ~small_data_t'(pend_addr.pop_front());
			if (err_armed)
				i_serr = 1'b1;
			else
				i_sack = 1'b1;
			err_armed = 1'b0;
		end
	end

	// Let every outstanding request answer
	task automatic drain();
		#2 i_wstb = 1'b0;
		@(posedge clk);
		while (resp_cnt != acc_cnt)
			@(posedge clk);
	endtask

	initial
	begin
		{i_wcyc, i_wstb, i_wwe, i_sstall, i_sack, i_serr} = '0;
		{i_waddr, i_wdata, i_wsel, i_sdata} = '0;
		//                 we    err   stall mask    addr          data                   sel
		tbl.push_back({1'b1, 1'b0, 8'h00, 25'h10,   64'h1122334455667788, 8'hff});
		tbl.push_back({1'b1, 1'b0, 8'h00, 25'h11,   64'hdeadbeefcafef00d, 8'hf0});
		tbl.push_back({1'b0, 1'b0, 8'h00, 25'h10,   64'h0,                8'hff});
		tbl.push_back({1'b0, 1'b0, 8'h06, 25'h2345, 64'h0,                8'hff});
		tbl.push_back({1'b1, 1'b0, 8'h1b, 25'h40,   64'h0123456789abcdef, 8'h0f});
		tbl.push_back({1'b0, 1'b1, 8'h00, 25'h41,   64'h0,                8'hff});
		tbl.push_back({1'b1, 1'b0, 8'h00, 25'h50,   64'ha5a55a5a3c3cc3c3, 8'h3c});
		tbl.push_back({1'b0, 1'b0, 8'h02, 25'h50,   64'h0,                8'hff});
		wait (rst_n);
		@(posedge clk);
		#2 i_wcyc = 1'b1;
		foreach (tbl[i])
		begin
			if (tbl[i].err)
			begin
				drain();
				err_armed = 1'b1;
			end
			#1 stall_bits = tbl[i].mask;
			#1 {i_wwe, i_waddr, i_wdata, i_wsel} =
				{tbl[i].we, tbl[i].addr, tbl[i].data, tbl[i].sel};
			i_wstb = 1'b1;
			do
			begin
				@(negedge clk);
				acc = !o_wstall;
				@(posedge clk);
			end while (!acc);
			acc_cnt++;
			if (tbl[i].err)
			begin
				drain();
				// Fresh bus cycle after the error
				#2 i_wcyc = 1'b0;
				@(posedge clk);
				#2 i_wcyc = 1'b1;
				@(posedge clk);
			end
		end
		drain();
		repeat (4) @(posedge clk);
		$display("Checks: %0d, errors: %0d, unanswered requests: %0d", checks, errors, pending);
		if (errors == 0 && pending == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// Watchdog allows 40 cycles per table entry once reset is over
	initial
	begin
		wait (rst_n === 1'b1);
		#(40 * tbl.size() * 20);
		$display("Timeout, the run did not finish in time");
		$display("Test failures found");
		$finish;
	end

endmodule

//--- project.f
verilog/wbdown_pkg.sv
verilog/wbdown_ctrl.sv
verilog/beat_counter.sv
verilog/req_shifter.sv
verilog/ack_fifo.sv
verilog/resp_assembler.sv
verilog/wbdown_top.sv
test/tb_clkgen.sv
test/tb_checker.sv
test/tb_wbdown.sv
